/* bench/cp_removal_sva.sv */
/*
  Protocol assertions for the cyclic prefix removal stage.
  Checks last against output valid, output valid against pop,
  list occupancy against the depth, and the write ready during
  clears and rotating pops. Bound where framer and list meet.
*/

`timescale 1ns/10ps
`default_nettype none

module cp_removal_sva (
  input logic                            clk,
  input logic                            rst,
  input ofdm_stream_pkg::framed_sample_t i_sample,
  input logic                            i_sample_valid,
  input logic                            i_pop,
  input logic                            i_clear,
  input logic                            i_repeat,
  input logic                            i_head_valid,
  input logic                            i_cp_len_ready,
  input logic [cp_cfg_pkg::OCC_W-1:0]    i_occupied
);

  import cp_cfg_pkg::*;

  localparam int DEPTH = 2**LIST_DEPTH_LOG2;

  // Last only marks a word that is actually offered
  last_needs_valid: assert property (@(posedge clk) disable iff (rst)
    i_sample.last |-> i_sample_valid)
    else $error("last raised without output valid");

  // The pop comes from CONFIG, where no sample is forwarded
  valid_not_with_pop: assert property (@(posedge clk) disable iff (rst)
    !(i_sample_valid && i_pop))
    else $error("output valid and pop high together");

  occupancy_in_range: assert property (@(posedge clk) disable iff (rst)
    i_occupied <= OCC_W'(DEPTH))
    else $error("list occupancy above its depth");

  // The tail slot belongs to the clear or to the rotated head in these cycles
  ready_low_on_clear_or_rotate: assert property (@(posedge clk) disable iff (rst)
    (i_clear || (i_pop && i_repeat && i_head_valid)) |-> !i_cp_len_ready)
    else $error("write ready high during clear or rotating pop");

endmodule : cp_removal_sva

bind cp_removal_top cp_removal_sva cp_removal_sva_inst (
  .clk            (clk),
  .rst            (rst),
  .i_sample       (o_sample),
  .i_sample_valid (o_sample_valid),
  .i_pop          (pop),
  .i_clear        (clear),
  .i_repeat       (i_cp_repeat),
  .i_head_valid   (head_valid),
  .i_cp_len_ready (o_cp_len_ready),
  .i_occupied     (o_cp_list_occupied)
);

`default_nettype wire

/* bench/cp_removal_tb.sv */
/*
  Testbench for the cyclic prefix removal stage.
  Clock and reset, LCG random stimulus, a queue model of the prefix list
  and of the symbol framing, the input sample driver, the output checker
  with random back-pressure, the check task and the final verdict.
*/

`timescale 1ns/10ps
`default_nettype none

module cp_removal_tb;

  import ofdm_stream_pkg::*;
  import cp_cfg_pkg::*;

  localparam logic [31:0] SEED       = 32'hcd12_38e2;
  localparam int          WAIT_MAX   = 4000;
  localparam int          LIST_DEPTH = 2**LIST_DEPTH_LOG2;

  logic             clk = 1'b0;
  logic             rst = 1'b1;
  cp_len_t          i_cp_len = '0;
  logic             i_cp_len_valid = 1'b0;
  logic             o_cp_len_ready;
  sym_len_t         i_symbol_len = '0;
  logic             i_cp_repeat = 1'b0;
  logic             i_clear_list = 1'b0;
  logic [OCC_W-1:0] o_cp_list_occupied;
  sample_t          i_sample = '0;
  logic             i_sample_valid = 1'b0;
  logic             o_sample_ready;
  framed_sample_t   o_sample;
  logic             o_sample_valid;
  logic             i_sample_ready = 1'b0;

  // Model of the list contents and of the length in force
  cp_len_t  list_q[$];
  cp_len_t  model_cp = DEFAULT_CP_LEN;
  sym_len_t cur_sym = '0;
  logic     cur_repeat = 1'b0;

  // Words still to be offered to the DUT and words still expected from it
  sample_t        drive_q[$];
  framed_sample_t expect_q[$];

  // Each process steps its own generator so the streams stay independent
  logic [31:0] stim_seed  = SEED;
  logic [31:0] drive_seed = SEED ^ 32'h5a5a_0001;
  logic [31:0] ready_seed = SEED ^ 32'ha5a5_0002;

  int mismatch_errors = 0;
  int other_errors    = 0;

  cp_removal_top cp_removal_top_inst (
    .clk                (clk),
    .rst                (rst),
    .i_cp_len           (i_cp_len),
    .i_cp_len_valid     (i_cp_len_valid),
    .o_cp_len_ready     (o_cp_len_ready),
    .i_symbol_len       (i_symbol_len),
    .i_cp_repeat        (i_cp_repeat),
    .i_clear_list       (i_clear_list),
    .o_cp_list_occupied (o_cp_list_occupied),
    .i_sample           (i_sample),
    .i_sample_valid     (i_sample_valid),
    .o_sample_ready     (o_sample_ready),
    .o_sample           (o_sample),
    .o_sample_valid     (o_sample_valid),
    .i_sample_ready     (i_sample_ready)
  );

  // 8 ns clock period
  always #4 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      mismatch_errors++;
      $display("Mismatch at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    other_errors++;
    $display("Error at %0t: timeout waiting for %s", $time, what);
    $display("Error count: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  // Upper LCG bits are used since the low bits of an LCG repeat quickly
  task automatic draw_cp_len(input int span, input int base, output cp_len_t value);
    stim_seed = lcg_next(stim_seed);
    value = cp_len_t'(base + int'(stim_seed[31:16]) % span);
  endtask

  // The input driver holds each word until the DUT takes it
  always @(posedge clk) begin : drive_samples
    logic taken;
    if (!rst) begin
      drive_seed = lcg_next(drive_seed);
      taken = i_sample_valid & o_sample_ready;
      if (taken) begin
        void'(drive_q.pop_front());
      end
      if (!i_sample_valid || taken) begin
        // About one cycle in four is left as a gap
        if (drive_q.size() > 0 && drive_seed[31:30] != 2'b00) begin
          i_sample       <= drive_q[0];
          i_sample_valid <= 1'b1;
        end else begin
          i_sample_valid <= 1'b0;
        end
      end
    end
  end

  // Output checker with random back-pressure
  always @(posedge clk) begin : check_output
    framed_sample_t want;
    if (!rst) begin
      ready_seed = lcg_next(ready_seed);
      if (o_sample_valid && i_sample_ready) begin
        if (expect_q.size() == 0) begin
          other_errors++;
          $display("Error at %0t: output sample appeared with none expected", $time);
        end else begin
          want = expect_q.pop_front();
          check_value(64'(o_sample), 64'(want), "output sample {data, user, last}");
        end
      end
      i_sample_ready <= (ready_seed[31:30] != 2'b00);
    end
  end

  task automatic set_config(input sym_len_t sym, input logic rpt);
    @(posedge clk);
    i_symbol_len <= sym;
    i_cp_repeat  <= rpt;
    cur_sym    = sym;
    cur_repeat = rpt;
  endtask

  // Waits for the handshake of a word already on the write port
  task automatic accept_cp_len(input cp_len_t value);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > WAIT_MAX) begin
        abort_on_timeout("prefix length write");
      end
    end while (!o_cp_len_ready);
    list_q.push_back(value);
    i_cp_len_valid <= 1'b0;
  endtask

  task automatic write_cp_len(input cp_len_t value);
    @(posedge clk);
    i_cp_len       <= value;
    i_cp_len_valid <= 1'b1;
    accept_cp_len(value);
  endtask

  task automatic clear_list();
    int cycles;
    @(posedge clk);
    i_clear_list <= 1'b1;
    @(posedge clk);
    i_clear_list <= 1'b0;
    list_q.delete();
    model_cp = DEFAULT_CP_LEN;
    // The CLEAR cycle is the one where the writer is held off
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > WAIT_MAX) begin
        abort_on_timeout("clear cycle");
      end
    end while (o_cp_len_ready);
    // Occupancy shows the empty list one cycle after the CLEAR cycle
    @(posedge clk);
    check_value(64'(o_cp_list_occupied), 64'(0), "occupancy after clear");
  endtask

  task automatic check_occupancy(input string what);
    @(posedge clk);
    check_value(64'(o_cp_list_occupied), 64'(list_q.size()), what);
  endtask

  // Builds the stimulus and expected output of n symbols, then waits for both to drain
  task automatic run_symbols(input int n);
    sample_t        s;
    framed_sample_t f;
    int             k;
    int             j;
    int             total;
    int             cycles;
    for (k = 0; k < n; k++) begin
      // Each symbol takes one head, which returns to the tail in repeat mode
      if (list_q.size() > 0) begin
        model_cp = list_q.pop_front();
        if (cur_repeat) begin
          list_q.push_back(model_cp);
        end
      end
      total = int'(model_cp) + int'(cur_sym);
      for (j = 0; j < total; j++) begin
        stim_seed = lcg_next(stim_seed);
        s.data = stim_seed;
        stim_seed = lcg_next(stim_seed);
        s.user = stim_seed[31];
        drive_q.push_back(s);
        if (j >= int'(model_cp)) begin
          f.data = s.data;
          f.user = s.user;
          f.last = (j == total - 1);
          expect_q.push_back(f);
        end
      end
    end
    cycles = 0;
    while (drive_q.size() != 0 || expect_q.size() != 0) begin
      @(posedge clk);
      cycles++;
      if (cycles > WAIT_MAX) begin
        abort_on_timeout("output samples");
      end
    end
    @(posedge clk);
  endtask

  initial begin : main_sequence
    cp_len_t value;
    int      i;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // Empty list after reset, so the default prefix applies
    set_config(9'd8, 1'b0);
    run_symbols(3);
    check_occupancy("occupancy after default symbols");

    // Lengths are used once each, then the last one stays
    set_config(9'd16, 1'b0);
    for (i = 0; i < 4; i++) begin
      draw_cp_len(13, 0, value);
      write_cp_len(value);
    end
    check_occupancy("occupancy after writes");
    for (i = 0; i < 6; i++) begin
      run_symbols(1);
      check_occupancy("occupancy while draining");
    end

    // Repeat mode rotates a fixed pattern
    clear_list();
    set_config(9'd16, 1'b1);
    for (i = 0; i < 3; i++) begin
      draw_cp_len(13, 0, value);
      write_cp_len(value);
    end
    for (i = 0; i < 7; i++) begin
      run_symbols(1);
      check_occupancy("occupancy in repeat mode");
    end

    // Clearing a loaded list brings back the default prefix
    clear_list();
    set_config(9'd1, 1'b0);
    run_symbols(3);

    // Zero prefix passes the whole symbol
    set_config(9'd16, 1'b0);
    write_cp_len(8'd0);
    run_symbols(2);

    // Zero symbol length only drops the prefix
    set_config(9'd0, 1'b0);
    for (i = 0; i < 2; i++) begin
      draw_cp_len(12, 1, value);
      write_cp_len(value);
    end
    run_symbols(3);
    check_occupancy("occupancy after zero length symbols");

    // A full list blocks the writer until a pop frees a slot
    clear_list();
    set_config(9'd8, 1'b0);
    for (i = 0; i < LIST_DEPTH; i++) begin
      draw_cp_len(13, 0, value);
      write_cp_len(value);
    end
    check_occupancy("occupancy of a full list");
    draw_cp_len(13, 0, value);
    @(posedge clk);
    i_cp_len       <= value;
    i_cp_len_valid <= 1'b1;
    for (i = 0; i < 4; i++) begin
      @(posedge clk);
      check_value(64'(o_cp_len_ready), 64'(0), "write ready with a full list");
    end
    fork
      accept_cp_len(value);
      run_symbols(1);
    join
    check_occupancy("occupancy after a pop frees a full list");

    // Longer run that drains the list and keeps the last length
    run_symbols(10);
    check_occupancy("occupancy after the long run");

    @(posedge clk);
    $display("Error count: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
    if (mismatch_errors == 0 && other_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule : cp_removal_tb

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the cyclic prefix removal testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module cp_removal_tb -f tb.f -o cp_removal_sim

output=$(./obj_dir/cp_removal_sim)
echo "$output"

if echo "$output" | grep -q "Simulation finished: PASS"; then
  exit 0
fi
exit 1

/* src/cp_cfg_pkg.sv */
/*
  Configuration definitions for cyclic prefix removal.
  Holds the prefix and symbol length widths, the framer counter width,
  the prefix list depth and occupancy width, and the default prefix length.
*/

`default_nettype none

package cp_cfg_pkg;

  localparam int CP_LEN_W  = 8;
  localparam int SYM_LEN_W = 9;

  // The framer counts both prefix and symbol samples with one counter
  localparam int COUNT_W = (CP_LEN_W > SYM_LEN_W) ? CP_LEN_W : SYM_LEN_W;

  // Eight entries in the prefix list, occupancy needs one extra bit to reach full
  localparam int LIST_DEPTH_LOG2 = 3;
  localparam int OCC_W           = LIST_DEPTH_LOG2 + 1;

  localparam logic [CP_LEN_W-1:0] DEFAULT_CP_LEN = 8'd4;

  typedef logic [CP_LEN_W-1:0]  cp_len_t;
  typedef logic [SYM_LEN_W-1:0] sym_len_t;

endpackage : cp_cfg_pkg

`default_nettype wire

/* src/cp_len_list.sv */
/*
  Prefix length list for cyclic prefix removal.
  Circular buffer of prefix lengths with a valid/ready write port,
  a head output for the framer, pop with optional rotation back
  to the tail, a clear that empties the list, and an occupancy count.
*/

`timescale 1ns/10ps
`default_nettype none

module cp_len_list (
  input  logic                         clk,
  input  logic                         rst,
  input  cp_cfg_pkg::cp_len_t          i_cp_len,
  input  logic                         i_cp_len_valid,
  output logic                         o_cp_len_ready,
  input  logic                         i_repeat,
  input  logic                         i_pop,
  input  logic                         i_clear,
  output cp_cfg_pkg::cp_len_t          o_head,
  output logic                         o_head_valid,
  output logic [cp_cfg_pkg::OCC_W-1:0] o_occupied
);

  import cp_cfg_pkg::*;

  cp_len_t                    mem [2**LIST_DEPTH_LOG2];
  logic [LIST_DEPTH_LOG2-1:0] wr_ptr;
  logic [LIST_DEPTH_LOG2-1:0] rd_ptr;
  logic [OCC_W-1:0]           count;
  logic                       full;
  logic                       pop_fire;
  logic                       rotate;
  logic                       wr_fire;
  cp_len_t                    wr_data;

  // The count reaches the depth exactly when its top bit is set
  assign full = count[LIST_DEPTH_LOG2];

  // The head is valid whenever something is stored
  assign o_head_valid = (count != '0);
  assign o_head       = mem[rd_ptr];
  assign o_occupied   = count;

  // A pop only removes an entry if one exists, and clear takes priority
  assign pop_fire = i_pop & o_head_valid & ~i_clear;

  // In repeat mode the popped head goes straight back in at the tail
  assign rotate = pop_fire & i_repeat;

  // The writer is held off when full, while clearing, and during a repeat pop
  // since the write slot is then taken by the rotated head
  assign o_cp_len_ready = ~full & ~i_clear & ~(i_pop & i_repeat);

  assign wr_fire = rotate | (i_cp_len_valid & o_cp_len_ready);
  assign wr_data = rotate ? o_head : i_cp_len;

  // Storage array, written at the tail
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (i_clear) begin
      // Clearing forgets every entry, stale data in the array is never read
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // A rotating pop writes and pops together so the count stays put
      case ({wr_fire, pop_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule : cp_len_list

`default_nettype wire

/* src/cp_removal_top.sv */
/*
  Top level of the cyclic prefix removal stage.
  Connects the prefix length list and the symbol framer
  to the configuration, status and sample stream ports.
*/

`timescale 1ns/10ps
`default_nettype none

module cp_removal_top (
  input  logic                            clk,
  input  logic                            rst,
  input  cp_cfg_pkg::cp_len_t             i_cp_len,
  input  logic                            i_cp_len_valid,
  output logic                            o_cp_len_ready,
  input  cp_cfg_pkg::sym_len_t            i_symbol_len,
  input  logic                            i_cp_repeat,
  input  logic                            i_clear_list,
  output logic [cp_cfg_pkg::OCC_W-1:0]    o_cp_list_occupied,
  input  ofdm_stream_pkg::sample_t        i_sample,
  input  logic                            i_sample_valid,
  output logic                            o_sample_ready,
  output ofdm_stream_pkg::framed_sample_t o_sample,
  output logic                            o_sample_valid,
  input  logic                            i_sample_ready
);

  import cp_cfg_pkg::*;

  // Head of the list and the control pulses back from the framer
  cp_len_t head;
  logic    head_valid;
  logic    pop;
  logic    clear;

  cp_len_list cp_len_list_inst (
    .clk            (clk),
    .rst            (rst),
    .i_cp_len       (i_cp_len),
    .i_cp_len_valid (i_cp_len_valid),
    .o_cp_len_ready (o_cp_len_ready),
    .i_repeat       (i_cp_repeat),
    .i_pop          (pop),
    .i_clear        (clear),
    .o_head         (head),
    .o_head_valid   (head_valid),
    .o_occupied     (o_cp_list_occupied)
  );

  cp_symbol_framer cp_symbol_framer_inst (
    .clk            (clk),
    .rst            (rst),
    .i_symbol_len   (i_symbol_len),
    .i_clear_list   (i_clear_list),
    .i_head         (head),
    .i_head_valid   (head_valid),
    .o_pop          (pop),
    .o_clear        (clear),
    .i_sample       (i_sample),
    .i_sample_valid (i_sample_valid),
    .o_sample_ready (o_sample_ready),
    .o_sample       (o_sample),
    .o_sample_valid (o_sample_valid),
    .i_sample_ready (i_sample_ready)
  );

endmodule : cp_removal_top

`default_nettype wire

/* src/cp_symbol_framer.sv */
/*
  Symbol framer for cyclic prefix removal.
  FSM that loads a prefix length per symbol from the list, drops the
  prefix samples, forwards the symbol samples with zero latency and
  marks the final symbol sample with last. Also sequences list clears.
*/

`timescale 1ns/10ps
`default_nettype none

module cp_symbol_framer (
  input  logic                           clk,
  input  logic                           rst,
  input  cp_cfg_pkg::sym_len_t           i_symbol_len,
  input  logic                           i_clear_list,
  input  cp_cfg_pkg::cp_len_t            i_head,
  input  logic                           i_head_valid,
  output logic                           o_pop,
  output logic                           o_clear,
  input  ofdm_stream_pkg::sample_t       i_sample,
  input  logic                           i_sample_valid,
  output logic                           o_sample_ready,
  output ofdm_stream_pkg::framed_sample_t o_sample,
  output logic                           o_sample_valid,
  input  logic                           i_sample_ready
);

  import cp_cfg_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CONFIG,
    ST_PREFIX,
    ST_SYMBOL,
    ST_CLEAR
  } state_t;

  state_t               state;
  cp_len_t              cp_len_reg;
  sym_len_t             sym_len_reg;
  logic [COUNT_W-1:0]   count;
  logic                 clear_pend;
  logic                 cfg_load;
  logic                 prefix_fire;
  logic                 symbol_fire;
  logic                 prefix_done;
  logic                 symbol_done;

  // A new symbol starts when a sample shows up in IDLE with no clear waiting
  assign cfg_load = (state == ST_IDLE) & ~clear_pend & i_sample_valid;

  // Prefix samples are dropped at one per cycle regardless of the output side
  assign prefix_fire = (state == ST_PREFIX) & i_sample_valid;
  assign symbol_fire = (state == ST_SYMBOL) & i_sample_valid & i_sample_ready;

  // The counter starts at one, so reaching the length means this is the final sample
  assign prefix_done = (count >= COUNT_W'(cp_len_reg));
  assign symbol_done = (count >= COUNT_W'(sym_len_reg));

  // The list is popped once per symbol and cleared from the CLEAR state
  assign o_pop   = (state == ST_CONFIG);
  assign o_clear = (state == ST_CLEAR);

  // Zero-latency sample path, only the handshake depends on the state
  assign o_sample_valid = (state == ST_SYMBOL) & i_sample_valid;
  assign o_sample_ready = (state == ST_PREFIX) | ((state == ST_SYMBOL) & i_sample_ready);

  always_comb begin
    o_sample.data = i_sample.data;
    o_sample.user = i_sample.user;
    // Last is qualified with valid so it never shows on an idle bus
    o_sample.last = (state == ST_SYMBOL) & i_sample_valid & symbol_done;
  end

  // The symbol length is sampled once per symbol and held while framing
  always_ff @(posedge clk) begin
    if (cfg_load) begin
      sym_len_reg <= i_symbol_len;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_IDLE;
      cp_len_reg <= DEFAULT_CP_LEN;
      count      <= COUNT_W'(1);
      clear_pend <= 1'b0;
    end else begin
      // Clear requests are remembered until the framer is back in IDLE
      if (state == ST_CLEAR) begin
        clear_pend <= i_clear_list;
      end else if (i_clear_list) begin
        clear_pend <= 1'b1;
      end

      case (state)
        ST_IDLE: begin
          count <= COUNT_W'(1);
          if (clear_pend) begin
            state <= ST_CLEAR;
          end else if (i_sample_valid) begin
            // An empty list leaves the previous prefix length in force
            if (i_head_valid) begin
              cp_len_reg <= i_head;
            end
            state <= ST_CONFIG;
          end
        end
        ST_CONFIG: begin
          if (cp_len_reg != '0) begin
            state <= ST_PREFIX;
          end else if (sym_len_reg != '0) begin
            state <= ST_SYMBOL;
          end else begin
            state <= ST_IDLE;
          end
        end
        ST_PREFIX: begin
          if (prefix_fire) begin
            count <= count + 1'b1;
            if (prefix_done) begin
              count <= COUNT_W'(1);
              state <= (sym_len_reg != '0) ? ST_SYMBOL : ST_IDLE;
            end
          end
        end
        ST_SYMBOL: begin
          // Back-pressure freezes the count along with the input
          if (symbol_fire) begin
            count <= count + 1'b1;
            if (symbol_done) begin
              count <= COUNT_W'(1);
              state <= ST_IDLE;
            end
          end
        end
        ST_CLEAR: begin
          cp_len_reg <= DEFAULT_CP_LEN;
          state      <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule : cp_symbol_framer

`default_nettype wire

/* src/ofdm_stream_pkg.sv */
/*
  Sample path definitions for the OFDM receive stream.
  Holds the complex sample width, the side-band user width,
  the input sample struct and the framed output sample struct.
*/

`default_nettype none

package ofdm_stream_pkg;

  // One complex sample, 16-bit I in the upper half and 16-bit Q in the lower half
  localparam int SAMPLE_W = 32;

  // Side-band user field that travels with every sample
  localparam int USER_W = 1;

  // Word carried on the input stream
  typedef struct packed {
    logic [SAMPLE_W-1:0] data;
    logic [USER_W-1:0]   user;
  } sample_t;

  // Word carried on the output stream, last marks the final sample of a symbol
  typedef struct packed {
    logic [SAMPLE_W-1:0] data;
    logic [USER_W-1:0]   user;
    logic                last;
  } framed_sample_t;

endpackage : ofdm_stream_pkg

`default_nettype wire

/* tb.f */
src/ofdm_stream_pkg.sv
src/cp_cfg_pkg.sv
src/cp_len_list.sv
src/cp_symbol_framer.sv
src/cp_removal_top.sv
bench/cp_removal_sva.sv
bench/cp_removal_tb.sv
